// File: build.f
common/cache_types_pkg.sv
common/cache_csr_pkg.sv
common/cache_be_if.sv
rtl/cache_control.sv
cache_memory/cache_tag_store.sv
cache_memory/cache_data_store.sv
rtl/cache_back_end.sv
rtl/cache_csr_block.sv
rtl/cache_top.sv
tb/cache_mem_model.sv
tb/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module cache_tb -f build.f -o cache_sim

out=$(./obj_dir/cache_sim)
echo "$out"

if echo "$out" | grep -qxF "=== PASS ==="; then
   exit 0
else
   exit 1
fi

// File: tb/cache_tb.sv
module cache_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ADDR_W        = 16;
   localparam int DATA_W        = 32;
   localparam int NLINES_W      = 4;
   localparam int WORD_OFFSET_W = 2;
   localparam int CNT_W         = 16;
   localparam int NBYTES_W      = $clog2(DATA_W / 8);
   localparam int WADDR_W       = ADDR_W - NBYTES_W;
   localparam int IDX_LO        = NBYTES_W + WORD_OFFSET_W;
   localparam int TAG_W         = ADDR_W - IDX_LO - NLINES_W;
   localparam int NLINES        = 2 ** NLINES_W;
   localparam int TIMEOUT       = 200;

   logic                     clk_i, rst_n_i;
   logic                     avalid_i, ready_o, rvalid_o;
   logic [ADDR_W-1:0]        addr_i;
   logic [DATA_W-1:0]        wdata_i, rdata_o;
   logic [DATA_W/8-1:0]      wstrb_i;
   logic                     be_avalid_o, be_ready_i, be_rvalid_i;
   logic [ADDR_W-1:0]        be_addr_o;
   logic [DATA_W-1:0]        be_wdata_o, be_rdata_i;
   logic [DATA_W/8-1:0]      be_wstrb_o;
   logic                     csr_valid_i, csr_we_i, csr_rvalid_o;
   cache_csr_pkg::csr_addr_t csr_addr_i;
   logic [DATA_W-1:0]        csr_wdata_i, csr_rdata_o;

   // reference state kept by the testbench
   logic [DATA_W-1:0] ref_mem [2**WADDR_W];
   logic              ref_valid [NLINES];
   logic [TAG_W-1:0]  ref_tag [NLINES];
   int                exp_cnt [4];
   int                errors, errors_at_start, passed, failed;
   logic              hung;
   string             cur_test;

   cache_top #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W),
      .WORD_OFFSET_W(WORD_OFFSET_W), .CNT_W(CNT_W)
   ) dut_i (.*);

   cache_mem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_i (
      .clk_i, .rst_n_i, .avalid_i(be_avalid_o), .addr_i(be_addr_o), .wdata_i(be_wdata_o),
      .wstrb_i(be_wstrb_o), .ready_o(be_ready_i), .rvalid_o(be_rvalid_i),
      .rdata_o(be_rdata_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   function automatic logic [DATA_W-1:0] expected_word(input logic [WADDR_W-1:0] w);
      return {2'b10, w, 2'b01, ~w};
   endfunction

   function automatic logic [NLINES_W-1:0] index_of(input logic [ADDR_W-1:0] a);
      return a[IDX_LO +: NLINES_W];
   endfunction

   function automatic logic [TAG_W-1:0] tag_of(input logic [ADDR_W-1:0] a);
      return a[ADDR_W-1 -: TAG_W];
   endfunction

   function automatic logic watched(input int sel);
      case (sel)
         0:       return ready_o;
         1:       return rvalid_o;
         default: return csr_rvalid_o;
      endcase
   endfunction

   // counts falling edges until the selected output is high
   task automatic wait_for(input int sel, input string what, output int cycles);
      cycles = 1;
      @(negedge clk_i);
      while (!watched(sel) && !hung) begin
         if (cycles >= TIMEOUT) begin
            $display("%s: no %s within %0d cycles", cur_test, what, TIMEOUT);
            hung = 1'b1;
            errors++;
         end else begin
            @(negedge clk_i);
            cycles++;
         end
      end
   endtask

   task automatic read_word(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] exp;
      logic              hit_exp;
      int                n, lat;
      if (hung)
         return;
      exp     = ref_mem[addr[ADDR_W-1:NBYTES_W]];
      hit_exp = ref_valid[index_of(addr)] && (ref_tag[index_of(addr)] == tag_of(addr));
      @(posedge clk_i);
      avalid_i <= 1'b1;
      addr_i   <= addr;
      wstrb_i  <= '0;
      wait_for(0, "ready_o", n);
      @(posedge clk_i);
      avalid_i <= 1'b0;
      wait_for(1, "rvalid_o", lat);
      if (hung)
         return;
      if (rdata_o !== exp) begin
         $display("[FAIL] %s: read %h expected %h actual %h", cur_test, addr, exp, rdata_o);
         errors++;
      end
      if (hit_exp && lat != 1) begin
         $display("[FAIL] %s: hit latency expected 1 actual %0d", cur_test, lat);
         errors++;
      end
      if (!hit_exp && lat < 2) begin
         $display("%s: read of %h answered like a hit, a miss was due", cur_test, addr);
         errors++;
      end
      exp_cnt[hit_exp ? 0 : 1]++;
      ref_valid[index_of(addr)] = 1'b1;
      ref_tag[index_of(addr)]   = tag_of(addr);
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [DATA_W/8-1:0] strb);
      logic hit_exp;
      int   n;
      if (hung)
         return;
      hit_exp = ref_valid[index_of(addr)] && (ref_tag[index_of(addr)] == tag_of(addr));
      @(posedge clk_i);
      avalid_i <= 1'b1;
      addr_i   <= addr;
      wdata_i  <= data;
      wstrb_i  <= strb;
      wait_for(0, "ready_o", n);
      @(posedge clk_i);
      avalid_i <= 1'b0;
      wstrb_i  <= '0;
      // ready_o returns once the write-through is acknowledged
      wait_for(0, "ready_o after the write-through", n);
      for (int b = 0; b < DATA_W / 8; b++) begin
         if (strb[b])
            ref_mem[addr[ADDR_W-1:NBYTES_W]][b*8 +: 8] = data[b*8 +: 8];
      end
      exp_cnt[hit_exp ? 2 : 3]++;
   endtask

   task automatic read_register(input cache_csr_pkg::csr_addr_t addr,
                                input logic [DATA_W-1:0] exp);
      int lat;
      if (hung)
         return;
      @(posedge clk_i);
      csr_valid_i <= 1'b1;
      csr_we_i    <= 1'b0;
      csr_addr_i  <= addr;
      @(posedge clk_i);
      csr_valid_i <= 1'b0;
      wait_for(2, "csr_rvalid_o", lat);
      if (hung)
         return;
      if (lat != 1) begin
         $display("%s: csr_rvalid_o came %0d cycles after the request", cur_test, lat);
         errors++;
      end
      if (csr_rdata_o !== exp) begin
         $display("[FAIL] %s: %s expected %h actual %h", cur_test, addr.name(), exp,
                  csr_rdata_o);
         errors++;
      end
   endtask

   task automatic write_register(input cache_csr_pkg::csr_addr_t addr,
                                 input logic [DATA_W-1:0] data);
      @(posedge clk_i);
      csr_valid_i <= 1'b1;
      csr_we_i    <= 1'b1;
      csr_addr_i  <= addr;
      csr_wdata_i <= data;
      @(posedge clk_i);
      csr_valid_i <= 1'b0;
      csr_we_i    <= 1'b0;
      if (addr == cache_csr_pkg::CSR_CTRL && data[cache_csr_pkg::CTRL_INVALIDATE_BIT]) begin
         for (int i = 0; i < NLINES; i++)
            ref_valid[i] = 1'b0;
      end
      if (addr == cache_csr_pkg::CSR_CTRL && data[cache_csr_pkg::CTRL_RESET_CNT_BIT]) begin
         for (int i = 0; i < 4; i++)
            exp_cnt[i] = 0;
      end
   endtask

   task automatic check_memory(input logic [ADDR_W-1:0] addr);
      logic [WADDR_W-1:0] w;
      w = addr[ADDR_W-1:NBYTES_W];
      if (mem_i.mem[w] !== ref_mem[w]) begin
         $display("[FAIL] %s: memory at %h expected %h actual %h", cur_test, addr,
                  ref_mem[w], mem_i.mem[w]);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test        = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         $display("ok   %s", cur_test);
         passed++;
      end else begin
         $display("%s failed with %0d wrong checks", cur_test, errors - errors_at_start);
         failed++;
      end
   endtask

   task automatic read_miss_then_hit();
      begin_test("read_miss_then_hit");
      read_word(16'h0124);
      read_word(16'h0124);
      read_register(cache_csr_pkg::CSR_READ_MISS_CNT, exp_cnt[1]);
      read_register(cache_csr_pkg::CSR_READ_HIT_CNT, exp_cnt[0]);
      end_test();
   endtask

   task automatic write_hit_merge();
      begin_test("write_hit_merge");
      write_word(16'h0124, 32'hcafe_f00d, 4'b0110);
      check_memory(16'h0124);
      read_word(16'h0124);
      end_test();
   endtask

   task automatic write_miss_no_allocate();
      begin_test("write_miss_no_allocate");
      write_word(16'h3a5c, 32'h1234_5678, 4'b1001);
      check_memory(16'h3a5c);
      read_word(16'h3a5c);
      end_test();
   endtask

   task automatic index_conflict_eviction();
      begin_test("index_conflict_eviction");
      // same index 6, tags 14 and 77
      repeat (2) begin
         read_word(16'h1460);
         read_word(16'h7768);
      end
      end_test();
   endtask

   task automatic invalidate_all();
      begin_test("invalidate_all");
      read_word(16'h0124);
      write_register(cache_csr_pkg::CSR_CTRL, 32'(1) << cache_csr_pkg::CTRL_INVALIDATE_BIT);
      read_word(16'h0124);
      read_word(16'h0124);
      end_test();
   endtask

   task automatic counter_readback();
      begin_test("counter_readback");
      for (int i = 0; i < 4; i++)
         read_register(cache_csr_pkg::csr_addr_t'(i), exp_cnt[i]);
      read_register(cache_csr_pkg::CSR_STATUS, '0);
      write_register(cache_csr_pkg::CSR_CTRL, 32'(1) << cache_csr_pkg::CTRL_RESET_CNT_BIT);
      for (int i = 0; i < 4; i++)
         read_register(cache_csr_pkg::csr_addr_t'(i), '0);
      end_test();
   endtask

   initial begin
      hung        = 1'b0;
      errors      = 0;
      passed      = 0;
      failed      = 0;
      rst_n_i     = 1'b0;
      avalid_i    = 1'b0;
      addr_i      = '0;
      wdata_i     = '0;
      wstrb_i     = '0;
      csr_valid_i = 1'b0;
      csr_we_i    = 1'b0;
      csr_addr_i  = cache_csr_pkg::CSR_READ_HIT_CNT;
      csr_wdata_i = '0;
      for (int w = 0; w < 2**WADDR_W; w++)
         ref_mem[w] = expected_word(WADDR_W'(w));
      for (int i = 0; i < NLINES; i++) begin
         ref_valid[i] = 1'b0;
         ref_tag[i]   = '0;
      end
      for (int i = 0; i < 4; i++)
         exp_cnt[i] = 0;

      repeat (8) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      if (ready_o !== 1'b1 || rvalid_o !== 1'b0 || be_avalid_o !== 1'b0 ||
          csr_rvalid_o !== 1'b0) begin
         $display("outputs are not in their idle state after reset");
         errors++;
      end

      read_miss_then_hit();
      write_hit_merge();
      write_miss_no_allocate();
      index_conflict_eviction();
      invalidate_all();
      counter_readback();

      $display("tests passed: %0d, tests failed: %0d", passed, failed);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: tb/cache_mem_model.sv
module cache_mem_model #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                avalid_i,
   input  logic [ADDR_W-1:0]   addr_i,
   input  logic [DATA_W-1:0]   wdata_i,
   input  logic [DATA_W/8-1:0] wstrb_i,
   output logic                ready_o,
   output logic                rvalid_o,
   output logic [DATA_W-1:0]   rdata_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NBYTES   = DATA_W / 8;
   localparam int NBYTES_W = $clog2(NBYTES);
   localparam int WADDR_W  = ADDR_W - NBYTES_W;

   logic [DATA_W-1:0]  mem [2**WADDR_W];
   logic [WADDR_W-1:0] waddr;
   integer             seed;

   assign waddr = addr_i[ADDR_W-1:NBYTES_W];

   // power-up contents, every word tied to its full word address
   function automatic logic [DATA_W-1:0] fill_word(input logic [WADDR_W-1:0] a);
      return DATA_W'({2'b10, a, 2'b01, ~a});
   endfunction

   initial begin
      seed     = 32'h50af1033;
      ready_o  = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      for (int i = 0; i < 2**WADDR_W; i++)
         mem[i] = fill_word(WADDR_W'(i));
      forever begin
         @(posedge clk_i);
         rvalid_o <= 1'b0;
         if (rst_n_i && avalid_i && ready_o) begin
            if (wstrb_i == '0) begin
               // read data comes back one cycle after acceptance
               rvalid_o <= 1'b1;
               rdata_o  <= mem[waddr];
            end else begin
               for (int b = 0; b < NBYTES; b++) begin
                  if (wstrb_i[b])
                     mem[waddr][b*8 +: 8] = wdata_i[b*8 +: 8];
               end
            end
         end
         // stall roughly one cycle in four
         ready_o <= (($random(seed) & 3) != 0);
      end
   end

endmodule

// File: rtl/cache_top.sv
module cache_top #(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2,
   parameter int CNT_W         = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   // front end
   input  logic                     avalid_i,
   input  logic [ADDR_W-1:0]        addr_i,
   input  logic [DATA_W-1:0]        wdata_i,
   input  logic [DATA_W/8-1:0]      wstrb_i,
   output logic                     ready_o,
   output logic                     rvalid_o,
   output logic [DATA_W-1:0]        rdata_o,
   // back-end bus
   output logic                     be_avalid_o,
   output logic [ADDR_W-1:0]        be_addr_o,
   output logic [DATA_W-1:0]        be_wdata_o,
   output logic [DATA_W/8-1:0]      be_wstrb_o,
   input  logic                     be_ready_i,
   input  logic                     be_rvalid_i,
   input  logic [DATA_W-1:0]        be_rdata_i,
   // software registers
   input  logic                     csr_valid_i,
   input  logic                     csr_we_i,
   input  cache_csr_pkg::csr_addr_t csr_addr_i,
   input  logic [DATA_W-1:0]        csr_wdata_i,
   output logic                     csr_rvalid_o,
   output logic [DATA_W-1:0]        csr_rdata_o
);
   cache_types_pkg::cache_event_t event_w;
   logic                     hit, tag_we, data_we, data_fill, busy, invalidate;
   logic [ADDR_W-1:0]        store_addr;
   logic [DATA_W/8-1:0]      data_wstrb;
   logic [DATA_W-1:0]        data_wdata;
   logic [WORD_OFFSET_W-1:0] data_idx;

   cache_be_if #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WORD_OFFSET_W(WORD_OFFSET_W)
   ) be_if ();

   cache_control #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WORD_OFFSET_W(WORD_OFFSET_W)
   ) control_i (
      .clk_i, .rst_n_i, .avalid_i, .addr_i, .wdata_i, .wstrb_i, .ready_o, .rvalid_o,
      .hit_i(hit), .addr_o(store_addr), .tag_we_o(tag_we), .data_we_o(data_we),
      .data_fill_o(data_fill), .data_wstrb_o(data_wstrb), .data_wdata_o(data_wdata),
      .data_idx_o(data_idx), .event_o(event_w), .busy_o(busy), .be(be_if)
   );

   cache_tag_store #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W), .WORD_OFFSET_W(WORD_OFFSET_W)
   ) tag_store_i (
      .clk_i, .rst_n_i, .addr_i(store_addr), .tag_we_i(tag_we),
      .invalidate_i(invalidate), .hit_o(hit)
   );

   cache_data_store #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W), .WORD_OFFSET_W(WORD_OFFSET_W)
   ) data_store_i (
      .clk_i, .addr_i(store_addr), .fill_idx_i(data_idx), .we_i(data_we),
      .fill_i(data_fill), .wstrb_i(data_wstrb), .wdata_i(data_wdata), .rdata_o
   );

   cache_back_end #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WORD_OFFSET_W(WORD_OFFSET_W)
   ) back_end_i (
      .clk_i, .rst_n_i, .be(be_if), .be_avalid_o, .be_addr_o, .be_wdata_o, .be_wstrb_o,
      .be_ready_i, .be_rvalid_i, .be_rdata_i
   );

   cache_csr_block #(
      .DATA_W(DATA_W), .CNT_W(CNT_W)
   ) csr_i (
      .clk_i, .rst_n_i, .event_i(event_w), .busy_i(busy), .csr_valid_i, .csr_we_i,
      .csr_addr_i, .csr_wdata_i, .csr_rvalid_o, .csr_rdata_o, .invalidate_o(invalidate)
   );

endmodule

// File: rtl/cache_csr_block.sv
module cache_csr_block #(
   parameter int DATA_W = 32,
   parameter int CNT_W  = 16
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  cache_types_pkg::cache_event_t event_i,
   input  logic                          busy_i,
   // software registers
   input  logic                          csr_valid_i,
   input  logic                          csr_we_i,
   input  cache_csr_pkg::csr_addr_t      csr_addr_i,
   input  logic [DATA_W-1:0]             csr_wdata_i,
   output logic                          csr_rvalid_o,
   output logic [DATA_W-1:0]             csr_rdata_o,
   output logic                          invalidate_o
);
   logic [CNT_W-1:0]  cnt_q [4];
   logic [DATA_W-1:0] rdata_d;
   logic              ctrl_wr, reset_cnt, ev_valid;
   logic [1:0]        ev_sel;

   assign ctrl_wr      = csr_valid_i && csr_we_i && (csr_addr_i == cache_csr_pkg::CSR_CTRL);
   assign reset_cnt    = ctrl_wr && csr_wdata_i[cache_csr_pkg::CTRL_RESET_CNT_BIT];
   assign invalidate_o = ctrl_wr && csr_wdata_i[cache_csr_pkg::CTRL_INVALIDATE_BIT];

   // event to counter slot, same order as the register map
   assign ev_valid = (event_i != cache_types_pkg::EV_NONE);
   assign ev_sel   = 2'(event_i - cache_types_pkg::EV_READ_HIT);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || reset_cnt) begin
         for (int i = 0; i < 4; i++)
            cnt_q[i] <= '0;
      end else if (ev_valid && !(&cnt_q[ev_sel])) begin
         cnt_q[ev_sel] <= cnt_q[ev_sel] + 1'b1;
      end
   end

   always_comb begin
      rdata_d = '0;
      case (csr_addr_i)
         cache_csr_pkg::CSR_READ_HIT_CNT:   rdata_d[CNT_W-1:0] = cnt_q[0];
         cache_csr_pkg::CSR_READ_MISS_CNT:  rdata_d[CNT_W-1:0] = cnt_q[1];
         cache_csr_pkg::CSR_WRITE_HIT_CNT:  rdata_d[CNT_W-1:0] = cnt_q[2];
         cache_csr_pkg::CSR_WRITE_MISS_CNT: rdata_d[CNT_W-1:0] = cnt_q[3];
         cache_csr_pkg::CSR_STATUS:         rdata_d[0] = busy_i;
         default:                           rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i)
         csr_rvalid_o <= 1'b0;
      else
         csr_rvalid_o <= csr_valid_i && !csr_we_i;
   end

   always_ff @(posedge clk_i) begin
      csr_rdata_o <= rdata_d;
   end

endmodule

// File: rtl/cache_back_end.sv
module cache_back_end #(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   cache_be_if.be              be,
   // back-end bus
   output logic                be_avalid_o,
   output logic [ADDR_W-1:0]   be_addr_o,
   output logic [DATA_W-1:0]   be_wdata_o,
   output logic [DATA_W/8-1:0] be_wstrb_o,
   input  logic                be_ready_i,
   input  logic                be_rvalid_i,
   input  logic [DATA_W-1:0]   be_rdata_i
);
   localparam int NBYTES_W = $clog2(DATA_W / 8);
   localparam int WADDR_W  = ADDR_W - NBYTES_W;

   cache_types_pkg::be_op_t  op_q;
   logic                     active_q, avalid_q, pending_q;
   logic [WORD_OFFSET_W-1:0] idx_q;
   logic [WADDR_W-1:0]       addr_q;
   logic [DATA_W-1:0]        wdata_q;
   logic [DATA_W/8-1:0]      wstrb_q;
   logic                     accepted, is_fill, last_word;

   assign accepted  = avalid_q && be_ready_i;
   assign is_fill   = (op_q == cache_types_pkg::BE_FILL);
   assign last_word = &idx_q;

   // one read outstanding at a time, next word issued after its data returns
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         active_q  <= 1'b0;
         avalid_q  <= 1'b0;
         pending_q <= 1'b0;
         idx_q     <= '0;
      end else if (be.req) begin
         active_q <= 1'b1;
         avalid_q <= 1'b1;
         idx_q    <= '0;
      end else begin
         if (accepted) begin
            avalid_q  <= 1'b0;
            pending_q <= is_fill;
            if (!is_fill)
               active_q <= 1'b0;
         end
         if (pending_q && be_rvalid_i) begin
            pending_q <= 1'b0;
            if (last_word) begin
               active_q <= 1'b0;
            end else begin
               idx_q    <= idx_q + 1'b1;
               avalid_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (be.req) begin
         op_q    <= be.op;
         addr_q  <= be.addr;
         wdata_q <= be.wdata;
         wstrb_q <= be.wstrb;
      end
   end

   assign be_avalid_o = avalid_q;
   assign be_addr_o   = is_fill ?
                        {addr_q[WADDR_W-1:WORD_OFFSET_W], idx_q, {NBYTES_W{1'b0}}} :
                        {addr_q, {NBYTES_W{1'b0}}};
   assign be_wdata_o  = wdata_q;
   assign be_wstrb_o  = is_fill ? '0 : wstrb_q;

   assign be.ack        = accepted && !is_fill;
   assign be.fill_valid = pending_q && be_rvalid_i;
   assign be.fill_idx   = idx_q;
   assign be.fill_data  = be_rdata_i;
   assign be.fill_last  = last_word;

   a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      be.req |-> !active_q);

   a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      be_rvalid_i |-> pending_q);

endmodule

// File: cache_memory/cache_data_store.sv
module cache_data_store #(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                     clk_i,
   input  logic [ADDR_W-1:0]        addr_i,
   input  logic [WORD_OFFSET_W-1:0] fill_idx_i,
   input  logic                     we_i,
   input  logic                     fill_i,
   input  logic [DATA_W/8-1:0]      wstrb_i,
   input  logic [DATA_W-1:0]        wdata_i,
   output logic [DATA_W-1:0]        rdata_o
);
   localparam int NBYTES   = DATA_W / 8;
   localparam int NBYTES_W = $clog2(NBYTES);

   logic [DATA_W-1:0]        mem_q [2**NLINES_W][2**WORD_OFFSET_W];
   logic [NLINES_W-1:0]      line;
   logic [WORD_OFFSET_W-1:0] word, wr_word;

   assign line    = addr_i[NBYTES_W+WORD_OFFSET_W +: NLINES_W];
   assign word    = addr_i[NBYTES_W +: WORD_OFFSET_W];
   // fill words carry their own index within the line
   assign wr_word = fill_i ? fill_idx_i : word;

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < NBYTES; b++) begin
         if (we_i && wstrb_i[b])
            mem_q[line][wr_word][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
   end

   assign rdata_o = mem_q[line][word];

endmodule

// File: cache_memory/cache_tag_store.sv
module cache_tag_store #(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int NLINES_W      = 4,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic              tag_we_i,
   input  logic              invalidate_i,
   output logic              hit_o
);
   localparam int NBYTES_W = $clog2(DATA_W / 8);
   localparam int TAG_W    = ADDR_W - NLINES_W - WORD_OFFSET_W - NBYTES_W;
   localparam int NLINES   = 2 ** NLINES_W;

   logic [NLINES-1:0] valid_q;
   logic [TAG_W-1:0]  tag_q [NLINES];
   logic [NLINES_W-1:0] index;
   logic [TAG_W-1:0]    tag;

   assign index = addr_i[NBYTES_W+WORD_OFFSET_W +: NLINES_W];
   assign tag   = addr_i[ADDR_W-1 -: TAG_W];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || invalidate_i)
         valid_q <= '0;
      else if (tag_we_i)
         valid_q[index] <= 1'b1;
   end

   always_ff @(posedge clk_i) begin
      if (tag_we_i)
         tag_q[index] <= tag;
   end

   assign hit_o = valid_q[index] && (tag_q[index] == tag);

endmodule

// File: rtl/cache_control.sv
module cache_control #(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int WORD_OFFSET_W = 2
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   // front end
   input  logic                          avalid_i,
   input  logic [ADDR_W-1:0]             addr_i,
   input  logic [DATA_W-1:0]             wdata_i,
   input  logic [DATA_W/8-1:0]           wstrb_i,
   output logic                          ready_o,
   output logic                          rvalid_o,
   // tag and data stores
   input  logic                          hit_i,
   output logic [ADDR_W-1:0]             addr_o,
   output logic                          tag_we_o,
   output logic                          data_we_o,
   output logic                          data_fill_o,
   output logic [DATA_W/8-1:0]           data_wstrb_o,
   output logic [DATA_W-1:0]             data_wdata_o,
   output logic [WORD_OFFSET_W-1:0]      data_idx_o,
   // status
   output cache_types_pkg::cache_event_t event_o,
   output logic                          busy_o,
   cache_be_if.ctrl                      be
);
   localparam int NBYTES_W = $clog2(DATA_W / 8);
   localparam int LADDR_W  = ADDR_W - NBYTES_W - WORD_OFFSET_W;

   cache_types_pkg::ctrl_state_t state_q, state_d;
   cache_types_pkg::be_op_t      op_q;
   logic                         req_q;
   logic [ADDR_W-1:0]            addr_q;
   logic [DATA_W-1:0]            wdata_q;
   logic [DATA_W/8-1:0]          wstrb_q;
   logic                         accept, is_write, filling, fill_done;

   assign ready_o   = (state_q == cache_types_pkg::IDLE);
   assign accept    = avalid_i && ready_o;
   assign is_write  = |wstrb_i;
   assign filling   = (state_q == cache_types_pkg::FILL);
   assign fill_done = filling && be.fill_valid && be.fill_last;

   always_comb begin
      state_d = state_q;
      case (state_q)
         cache_types_pkg::IDLE: begin
            if (accept) begin
               if (is_write)
                  state_d = cache_types_pkg::WRITE_THROUGH;
               else if (hit_i)
                  state_d = cache_types_pkg::RESPOND;
               else
                  state_d = cache_types_pkg::FILL;
            end
         end
         cache_types_pkg::RESPOND:       state_d = cache_types_pkg::IDLE;
         cache_types_pkg::FILL:          if (fill_done) state_d = cache_types_pkg::RESPOND;
         cache_types_pkg::WRITE_THROUGH: if (be.ack) state_d = cache_types_pkg::IDLE;
         default:                        state_d = cache_types_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= cache_types_pkg::IDLE;
         req_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         // every write goes through, reads only on a miss
         req_q   <= accept && (is_write || !hit_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
         op_q    <= is_write ? cache_types_pkg::BE_WRITE : cache_types_pkg::BE_FILL;
      end
   end

   // stores look at the incoming address only while idle
   assign addr_o = ready_o ? addr_i : addr_q;

   // write hits update the line at acceptance, fills as words arrive
   assign data_we_o    = (accept && is_write && hit_i) || (filling && be.fill_valid);
   assign data_fill_o  = filling;
   assign data_idx_o   = be.fill_idx;
   assign data_wstrb_o = filling ? '1 : wstrb_i;
   assign data_wdata_o = filling ? be.fill_data : wdata_i;
   assign tag_we_o     = fill_done;

   assign rvalid_o = (state_q == cache_types_pkg::RESPOND);
   assign busy_o   = !ready_o;

   always_comb begin
      event_o = cache_types_pkg::EV_NONE;
      if (accept) begin
         if (is_write)
            event_o = hit_i ? cache_types_pkg::EV_WRITE_HIT : cache_types_pkg::EV_WRITE_MISS;
         else
            event_o = hit_i ? cache_types_pkg::EV_READ_HIT : cache_types_pkg::EV_READ_MISS;
      end
   end

   // line base for a fill, word address for a write
   assign be.req   = req_q;
   assign be.op    = op_q;
   assign be.addr  = (op_q == cache_types_pkg::BE_FILL) ?
                     {addr_q[ADDR_W-1 -: LADDR_W], {WORD_OFFSET_W{1'b0}}} :
                     addr_q[ADDR_W-1:NBYTES_W];
   assign be.wdata = wdata_q;
   assign be.wstrb = wstrb_q;

   // a response always comes from a line that holds the address
   a_rvalid_from_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_o |-> hit_i);

   a_req_on_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(be.req) |-> $past(state_q) == cache_types_pkg::IDLE &&
         (state_q inside {cache_types_pkg::FILL, cache_types_pkg::WRITE_THROUGH}));

endmodule

// File: common/cache_be_if.sv
interface cache_be_if #(
   parameter int ADDR_W        = 16,
   parameter int DATA_W        = 32,
   parameter int WORD_OFFSET_W = 2
);
   localparam int NBYTES_W = $clog2(DATA_W / 8);

   // request side
   logic                         req;
   cache_types_pkg::be_op_t      op;
   logic [ADDR_W-NBYTES_W-1:0]   addr;
   logic [DATA_W-1:0]            wdata;
   logic [DATA_W/8-1:0]          wstrb;

   // completion side
   logic                         ack;
   logic                         fill_valid;
   logic [WORD_OFFSET_W-1:0]     fill_idx;
   logic [DATA_W-1:0]            fill_data;
   logic                         fill_last;

   modport ctrl (
      output req, op, addr, wdata, wstrb,
      input  ack, fill_valid, fill_idx, fill_data, fill_last
   );

   modport be (
      input  req, op, addr, wdata, wstrb,
      output ack, fill_valid, fill_idx, fill_data, fill_last
   );
endinterface

// File: common/cache_csr_pkg.sv
package cache_csr_pkg;

   // software register map
   typedef enum logic [2:0] {
      CSR_READ_HIT_CNT   = 3'd0,
      CSR_READ_MISS_CNT  = 3'd1,
      CSR_WRITE_HIT_CNT  = 3'd2,
      CSR_WRITE_MISS_CNT = 3'd3,
      CSR_CTRL           = 3'd4,
      CSR_STATUS         = 3'd5
   } csr_addr_t;

   // control register bits, both self-clearing
   localparam int CTRL_RESET_CNT_BIT  = 0;
   localparam int CTRL_INVALIDATE_BIT = 1;

endpackage

// File: common/cache_types_pkg.sv
package cache_types_pkg;

   // controller states
   typedef enum logic [1:0] {
      IDLE,
      RESPOND,
      FILL,
      WRITE_THROUGH
   } ctrl_state_t;

   // at most one event per cycle, raised when a request is accepted
   typedef enum logic [2:0] {
      EV_NONE,
      EV_READ_HIT,
      EV_READ_MISS,
      EV_WRITE_HIT,
      EV_WRITE_MISS
   } cache_event_t;

   // back-end operations
   typedef enum logic {
      BE_FILL,
      BE_WRITE
   } be_op_t;

endpackage
